// ==== rtl/cpu_macros.svh ====
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// datapath widths
`define CPU_DATA_W 8
`define CPU_ADDR_W 16
`define CPU_FLAG_W 4
`define CPU_OP_W   4
`define CPU_REG_W  2

`define CPU_RESET_IP 16'h0000 // first fetch address

// stored flag bit positions
`define FLAG_Z 0
`define FLAG_C 1 // set = carry out, on sub set = no borrow
`define FLAG_N 2
`define FLAG_V 3

// instruction fields
`define IR_OP_HI      6
`define IR_OP_LO      3
`define IR_DST_BIT    2 // alu: 0 = result to a, 1 = result to dd
`define IR_INV_BIT    2 // jc: invert tested flag
`define IR_ALWAYS_BIT 3 // 1 = jmp, 0 = jc
`define IR_ST_SRC     0 // st: 0 = a, 1 = b

// class codes on ir[7:4], jumps on ir[7:6]
`define OPC_LD  4'b1000
`define OPC_ST  4'b1001
`define OPC_LDI 4'b1010
`define OPC_JMP 2'b11

// alu operation codes, ir[6:3]
`define ALU_ADD  4'h0
`define ALU_ADC  4'h1
`define ALU_SUB  4'h2
`define ALU_SBC  4'h3
`define ALU_AND  4'h4
`define ALU_OR   4'h5
`define ALU_XOR  4'h6
`define ALU_PASS 4'h7 // returns y
`define ALU_NOT  4'h8
`define ALU_SHL  4'h9
`define ALU_SHR  4'hA
`define ALU_ROL  4'hB
`define ALU_ROR  4'hC
`define ALU_INC  4'hD
`define ALU_DEC  4'hE
`define ALU_CMP  4'hF // flags only

// register codes dd
`define REG_A  2'b00
`define REG_B  2'b01
`define REG_PL 2'b10
`define REG_PH 2'b11

`endif

// ==== rtl/cpu_pkg.sv ====
`include "cpu_macros.svh"

package cpu_pkg;

    // data byte on the bus and in every register
    typedef logic [`CPU_DATA_W-1:0] byte_t;

    // memory address, ip and the ph:pl pointer
    typedef logic [`CPU_ADDR_W-1:0] addr_t;

    // stored flags
    // bit 0 zero
    // bit 1 carry
    // bit 2 negative
    // bit 3 overflow
    typedef logic [`CPU_FLAG_W-1:0] flags_t;

    typedef logic [`CPU_OP_W-1:0] alu_op_t; // from ir[6:3]

    typedef logic [`CPU_REG_W-1:0] reg_sel_t; // dd field

    // two-cycle sequencer
    // fetch loads ir and bumps ip
    // exec runs the decoded instruction
    typedef enum logic {
        FETCH = 1'b0,
        EXEC  = 1'b1
    } seq_state_t;

endpackage

// ==== rtl/cpu_alu.sv ====
`include "cpu_macros.svh"

module cpu_alu (
    input  cpu_pkg::alu_op_t op,
    input  cpu_pkg::byte_t   x,
    input  cpu_pkg::byte_t   y,
    input  logic             carry_in,
    output cpu_pkg::byte_t   result,
    output cpu_pkg::flags_t  flags_next
);

    cpu_pkg::byte_t       add_b;   // second adder input
    logic                 add_c;   // adder carry in
    logic [`CPU_DATA_W:0] sum;     // carry out in the top bit
    logic                 arith;   // op uses the adder
    logic                 carry;
    logic                 add_ovf;

    // one adder, sub is x + ~y + 1
    always_comb begin
        add_b = y;
        add_c = 1'b0;
        case (op)
            `ALU_ADC:           add_c = carry_in;
            `ALU_SUB, `ALU_CMP: begin
                add_b = ~y;
                add_c = 1'b1;
            end
            `ALU_SBC: begin
                add_b = ~y;
                add_c = carry_in; // carry clear = borrow pending
            end
            `ALU_INC: begin
                add_b = '0;
                add_c = 1'b1;
            end
            `ALU_DEC:           add_b = '1;
            default:            add_c = 1'b0;
        endcase
    end

    assign sum = {1'b0, x} + {1'b0, add_b} + {{`CPU_DATA_W{1'b0}}, add_c};

    // same-sign inputs, result sign flipped
    assign add_ovf = (x[7] == add_b[7]) & (sum[7] != x[7]);

    always_comb begin
        result = sum[`CPU_DATA_W-1:0];
        carry  = carry_in; // logic ops keep carry
        arith  = 1'b0;
        case (op)
            `ALU_AND:  result = x & y;
            `ALU_OR:   result = x | y;
            `ALU_XOR:  result = x ^ y;
            `ALU_PASS: result = y;
            `ALU_NOT:  result = ~x;
            `ALU_SHL: begin
                result = {x[6:0], 1'b0};
                carry  = x[7];
            end
            `ALU_SHR: begin
                result = {1'b0, x[7:1]};
                carry  = x[0];
            end
            `ALU_ROL: begin
                result = {x[6:0], x[7]};
                carry  = x[7];
            end
            `ALU_ROR: begin
                result = {x[0], x[7:1]};
                carry  = x[0];
            end
            default: begin // add, adc, sub, sbc, inc, dec, cmp
                carry = sum[`CPU_DATA_W];
                arith = 1'b1;
            end
        endcase
    end

    assign flags_next[`FLAG_Z] = (result == '0);
    assign flags_next[`FLAG_C] = carry;
    assign flags_next[`FLAG_N] = result[7];
    assign flags_next[`FLAG_V] = arith & add_ovf;

endmodule

// ==== rtl/cpu_control.sv ====
`include "cpu_macros.svh"

module cpu_control (
    input  logic              clk,
    input  logic              rst,
    input  cpu_pkg::byte_t    ir,
    input  cpu_pkg::flags_t   flags,
    output logic              ir_we,     // latch rdata into ir
    output logic              ip_inc,
    output logic              addr_dp,   // bus address from ph:pl instead of ip
    output logic [3:0]        reg_we,    // one-hot, bit n = register code n
    output logic              load_sel,  // 1 = rdata, 0 = alu result
    output logic              store_sel, // 1 = b, 0 = a
    output logic              flags_we,
    output logic              swap_p,    // exchange ip and ph:pl
    output logic              mem_we,
    output cpu_pkg::alu_op_t  alu_op,
    output logic              op_swap,   // alu operands exchanged
    output cpu_pkg::reg_sel_t y_sel
);

    // opcode map
    // 0oooo0dd  alu  a  <- op(a, dd)
    // 0oooo1dd  alu  dd <- op(dd, a)
    // 1000__dd  ld   dd <- [dp]
    // 1001___s  st   s -> [dp]
    // 1010__dd  ldi  dd <- [ip++]
    // 11000cff  jc   swap ip, dp if flag ff xor c
    // 11001___  jmp  swap ip, dp

    cpu_pkg::seq_state_t state;

    logic       exec;
    logic       is_alu;
    logic       is_ld;
    logic       is_st;
    logic       is_ldi;
    logic       is_jmp;
    logic       is_cmp;
    logic       cond;       // jump condition
    logic [3:0] dst_onehot; // dd decoded
    logic [3:0] alu_dst;

    // strict fetch/exec alternation, no waits
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= cpu_pkg::FETCH;
        end else if (state == cpu_pkg::FETCH) begin
            state <= cpu_pkg::EXEC;
        end else begin
            state <= cpu_pkg::FETCH;
        end
    end

    assign exec = (state == cpu_pkg::EXEC);

    // instruction classes
    assign is_alu = ~ir[7];
    assign is_ld  = (ir[7:4] == `OPC_LD);
    assign is_st  = (ir[7:4] == `OPC_ST);
    assign is_ldi = (ir[7:4] == `OPC_LDI);
    assign is_jmp = (ir[7:6] == `OPC_JMP);
    assign is_cmp = (alu_op == `ALU_CMP);

    // flag picked by ff, polarity by c, bit 3 forces the jump
    assign cond = (ir[`IR_INV_BIT] ^ flags[ir[1:0]]) | ir[`IR_ALWAYS_BIT];

    assign dst_onehot = 4'b0001 << ir[1:0];

    // alu result goes to a unless the dst bit is set
    assign alu_dst = ir[`IR_DST_BIT] ? dst_onehot : 4'b0001;

    always_comb begin
        reg_we = 4'b0000;
        if (exec) begin
            if (is_ld || is_ldi) begin
                reg_we = dst_onehot;
            end else if (is_alu && !is_cmp) begin
                reg_we = alu_dst; // cmp writes flags only
            end
        end
    end

    // fetch strobes
    assign ir_we  = ~exec;
    assign ip_inc = ~exec | (exec & is_ldi); // ldi consumes its immediate

    // exec strobes
    assign addr_dp  = exec & (is_ld | is_st);
    assign mem_we   = exec & is_st;
    assign flags_we = exec & is_alu;
    assign swap_p   = exec & is_jmp & cond;

    // selects straight from ir, only meaningful with a strobe
    assign load_sel  = is_ld | is_ldi;
    assign store_sel = ir[`IR_ST_SRC];
    assign alu_op    = ir[`IR_OP_HI:`IR_OP_LO];
    assign op_swap   = ir[`IR_DST_BIT];
    assign y_sel     = ir[1:0];

endmodule

// ==== rtl/cpu_regs.sv ====
`include "cpu_macros.svh"

module cpu_regs (
    input  logic              clk,
    input  logic              rst,
    input  cpu_pkg::byte_t    rdata,
    input  cpu_pkg::byte_t    result,
    input  cpu_pkg::flags_t   flags_next,
    input  logic              ir_we,
    input  logic              ip_inc,
    input  logic              addr_dp,
    input  logic [3:0]        reg_we,
    input  logic              load_sel,
    input  logic              store_sel,
    input  logic              flags_we,
    input  logic              swap_p,
    input  logic              op_swap,
    input  cpu_pkg::reg_sel_t y_sel,
    output cpu_pkg::byte_t    ir,
    output cpu_pkg::flags_t   flags,
    output cpu_pkg::addr_t    addr,
    output cpu_pkg::byte_t    wdata,
    output cpu_pkg::byte_t    x,
    output cpu_pkg::byte_t    y,
    output logic              carry_in
);

    cpu_pkg::byte_t a_q;
    cpu_pkg::byte_t b_q;
    cpu_pkg::byte_t pl_q;
    cpu_pkg::byte_t ph_q;
    cpu_pkg::addr_t ip;
    cpu_pkg::addr_t dp;      // ph:pl
    cpu_pkg::byte_t ld_data; // register write data
    cpu_pkg::byte_t sel_val; // register picked by dd, code 00 reads zero

    assign dp = {ph_q, pl_q};

    // sequencing state
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            ip    <= `CPU_RESET_IP;
            ir    <= '0;
            flags <= '0;
        end else begin
            if (ir_we) begin
                ir <= rdata;
            end
            if (flags_we) begin
                flags <= flags_next;
            end
            if (swap_p) begin
                ip <= dp; // jump target
            end else if (ip_inc) begin
                ip <= ip + cpu_pkg::addr_t'(1);
            end
        end
    end

    assign ld_data = load_sel ? rdata : result;

    // working registers
    always_ff @(posedge clk) begin
        if (reg_we[`REG_A]) begin
            a_q <= ld_data;
        end
        if (reg_we[`REG_B]) begin
            b_q <= ld_data;
        end
        if (swap_p) begin
            {ph_q, pl_q} <= ip; // return address, already past the jump
        end else begin
            if (reg_we[`REG_PL]) pl_q <= ld_data;
            if (reg_we[`REG_PH]) ph_q <= ld_data;
        end
    end

    always_comb begin
        case (y_sel)
            `REG_A:  sel_val = '0;
            `REG_B:  sel_val = b_q;
            `REG_PL: sel_val = pl_q;
            default: sel_val = ph_q;
        endcase
    end

    // swapped form computes op(dd, a)
    assign x = op_swap ? sel_val : a_q;
    assign y = op_swap ? a_q : sel_val;

    assign carry_in = flags[`FLAG_C];

    assign addr  = addr_dp ? dp : ip;
    assign wdata = store_sel ? b_q : a_q;

endmodule

// ==== rtl/cpu_top.sv ====
module cpu_top (
    input  logic           clk,
    input  logic           rst,
    input  cpu_pkg::byte_t rdata,  // combinational memory read
    output cpu_pkg::addr_t addr,
    output cpu_pkg::byte_t wdata,
    output logic           mem_we  // write at the closing rising edge
);

    // control to registers
    logic              ir_we;
    logic              ip_inc;
    logic              addr_dp;
    logic [3:0]        reg_we;
    logic              load_sel;
    logic              store_sel;
    logic              flags_we;
    logic              swap_p;
    logic              op_swap;
    cpu_pkg::reg_sel_t y_sel;
    cpu_pkg::alu_op_t  alu_op;   // straight to the alu

    // registers back to control
    cpu_pkg::byte_t    ir;
    cpu_pkg::flags_t   flags;

    // alu operands and results
    cpu_pkg::byte_t    x;
    cpu_pkg::byte_t    y;
    logic              carry_in;
    cpu_pkg::byte_t    result;
    cpu_pkg::flags_t   flags_next;

    cpu_control ctrl0 (
        .clk, .rst, .ir, .flags,
        .ir_we, .ip_inc, .addr_dp, .reg_we, .load_sel, .store_sel,
        .flags_we, .swap_p, .mem_we, .alu_op, .op_swap, .y_sel
    );

    cpu_regs regs0 (
        .clk, .rst, .rdata, .result, .flags_next,
        .ir_we, .ip_inc, .addr_dp, .reg_we, .load_sel, .store_sel,
        .flags_we, .swap_p, .op_swap, .y_sel,
        .ir, .flags, .addr, .wdata, .x, .y, .carry_in
    );

    cpu_alu alu0 (
        .op         (alu_op),
        .x          (x),
        .y          (y),
        .carry_in   (carry_in),
        .result     (result),
        .flags_next (flags_next)
    );

endmodule

// ==== testbench/cpu_props.sv ====
module cpu_props (
    input logic                clk,
    input logic                rst,
    input cpu_pkg::seq_state_t state,
    input cpu_pkg::byte_t      ir,
    input logic                flags_we,
    input cpu_pkg::flags_t     flags
);

    // ir only reloads on a fetch edge
    a_ir_hold: assert property (@(posedge clk) disable iff (!rst)
        state == cpu_pkg::EXEC |=> $stable(ir))
        else $error("ir changed at the end of exec");

    // flags move only with an alu exec
    a_flags_hold: assert property (@(posedge clk) disable iff (!rst)
        !flags_we |=> $stable(flags))
        else $error("flags changed without flags_we");

    // first cycle out of reset is a fetch
    a_reset_fetch: assert property (@(posedge clk)
        $rose(rst) |-> state == cpu_pkg::FETCH)
        else $error("first cycle after reset is not a fetch");

endmodule

bind cpu_control cpu_props props0 (
    .clk      (clk),
    .rst      (rst),
    .state    (state),
    .ir       (ir),
    .flags_we (flags_we),
    .flags    (flags)
);

// ==== testbench/tb_cpu.sv ====
module tb_cpu;

    logic           clk = 1'b0;
    logic           rst;
    cpu_pkg::byte_t rdata = '0;
    cpu_pkg::addr_t addr;
    cpu_pkg::byte_t wdata;
    logic           mem_we;

    cpu_pkg::byte_t mem [0:65535]; // external memory, 64 KiB

    cpu_pkg::addr_t exp_addr [$];  // expected stores in order
    cpu_pkg::byte_t exp_data [$];
    int             n_instr;       // instructions the program runs
    int             limit = 0;     // cycle budget, set from the trace
    int             cycles = 0;
    int             n_stores = 0;

    cpu_top dut0 (
        .clk    (clk),
        .rst    (rst),
        .rdata  (rdata),
        .addr   (addr),
        .wdata  (wdata),
        .mem_we (mem_we)
    );

    always #10 clk = ~clk;

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Simulation FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_addr(input string name, input cpu_pkg::addr_t exp,
                              input cpu_pkg::addr_t act);
        if (act !== exp) begin
            abort_run($sformatf("ERR %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_data(input string name, input cpu_pkg::byte_t exp,
                              input cpu_pkg::byte_t act);
        if (act !== exp) begin
            abort_run($sformatf("ERR %s expected %h actual %h", name, exp, act));
        end
    endtask

    // background pattern, every address bit matters
    task automatic fill_memory();
        for (int i = 0; i < 65536; i++) begin
            mem[i] = cpu_pkg::byte_t'(i[7:0] ^ i[15:8] ^ 8'h5c);
        end
    endtask

    // P lines carry up to eight bytes from a start address
    task automatic load_trace();
        int             fd;
        int             n;
        string          line;
        cpu_pkg::addr_t a;
        cpu_pkg::byte_t v [8];
        fd = $fopen("testbench/cpu_trace.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open the trace file testbench/cpu_trace.txt");
        end
        while ($fgets(line, fd) > 0) begin
            case (line.getc(0))
                "P": begin
                    n = $sscanf(line, "P %h %h %h %h %h %h %h %h %h", a,
                                v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]);
                    for (int k = 0; k < n - 1; k++) begin
                        mem[a + cpu_pkg::addr_t'(k)] = v[k];
                    end
                end
                "S": begin
                    n = $sscanf(line, "S %h %h", a, v[0]);
                    exp_addr.push_back(a);
                    exp_data.push_back(v[0]);
                end
                "N": n = $sscanf(line, "N %d", n_instr);
                default: ; // comment or blank
            endcase
        end
        $fclose(fd);
    endtask

    // bus side of memory, all on the falling edge
    always @(negedge clk) begin
        if (mem_we) begin
            if (!rst) begin
                abort_run("memory write strobe seen while reset is asserted");
            end
            if (n_stores >= exp_addr.size()) begin
                abort_run($sformatf("unexpected store to %h after the last one", addr));
            end
            check_addr($sformatf("store%0d_addr", n_stores), exp_addr[n_stores], addr);
            check_data($sformatf("store%0d_data", n_stores), exp_data[n_stores], wdata);
            mem[addr] = wdata;
            n_stores++;
        end
        rdata <= mem[addr]; // combinational read, held until next fall
    end

    always @(negedge clk) begin
        if (rst === 1'b1) begin
            cycles++;
            if (cycles > limit) begin
                abort_run($sformatf("timeout, no finish after %0d cycles", limit));
            end
        end
    end

    initial begin
        rst = 1'b0;
        fill_memory();
        load_trace();
        limit = 2 * n_instr + 20;
        repeat (3) @(posedge clk); // three rising edges in reset
        @(negedge clk);
        rst = 1'b1;
        check_addr("reset_fetch", '0, addr); // first fetch from 0
        while (n_stores < exp_addr.size()) begin
            @(posedge clk); // store count only moves on falling edges
        end
        repeat (8) @(posedge clk); // four more instructions, quiet bus
        $display("Simulation PASSED");
        $finish;
    end

endmodule

// ==== testbench/cpu_trace.txt ====
# P addr b0..b7 program bytes, S addr value expected store in order
# N count instructions run before the end check
P 0000 A3 00 A2 E0 A0 5A A1 C3
P 0008 90 A2 E1 91 A2 E0 81 A2
P 0010 E2 91 A1 33 01 A2 E3 90
P 0018 11 A2 E4 90 21 A2 E5 90
P 0020 29 A2 E6 90 32 A2 E7 90
P 0028 48 A2 E8 90 50 A2 E9 90
P 0030 60 A2 EA 90 58 A2 EB 90
P 0038 68 A2 EC 90 70 A2 ED 90
P 0040 38 A2 EE 90 A0 10 15 A2
P 0048 EF 91 06 90 7D A2 F0 91
P 0050 A1 01 A0 01 19 A0 A1 A2
P 0058 5C C0 A0 B1 A2 F1 90 A0
P 0060 A2 A2 66 C4 A0 B2 A2 F2
P 0068 90 A0 A3 A2 70 C1 A0 B3
P 0070 A2 F3 90 A0 A4 A2 7A C5
P 0078 A0 B4 A2 F4 90 A0 7F 09
P 0080 A0 A5 A2 87 C2 A0 B5 A2
P 0088 F5 90 A0 A6 A2 91 C6 A0
P 0090 B6 A2 F6 90 A0 A7 A2 9B
P 0098 C3 A0 B7 A2 F7 90 A0 A8
P 00A0 A2 A5 C7 A0 B8 A2 F8 90
P 00A8 A2 AD C8 00 00 3A 90 A2
P 00B0 AF C8
S 00E0 5A
S 00E1 C3
S 00E2 5A
S 00E3 8D
S 00E4 5A
S 00E5 12
S 00E6 33
S 00E7 D5
S 00E8 AA
S 00E9 55
S 00EA AA
S 00EB 55
S 00EC 56
S 00ED 55
S 00EE 00
S 00EF 23
S 00FF 10
S 00F0 23
S 00F1 A1
S 00F2 B2
S 00F3 A3
S 00F4 B4
S 00F5 A5
S 00F6 B6
S 00F7 A7
S 00F8 B8
S 00AB AB
N 114

// ==== project.f ====
+incdir+rtl
rtl/cpu_pkg.sv
rtl/cpu_alu.sv
rtl/cpu_control.sv
rtl/cpu_regs.sv
rtl/cpu_top.sv
testbench/cpu_props.sv
testbench/tb_cpu.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the cpu testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f project.f --top-module tb_cpu -o sim_cpu

# keep going on a failing run so the log can be judged
./obj_dir/sim_cpu > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation PASSED" sim.log; then
    exit 0
else
    exit 1
fi
